//--- hdl/spi_msg_pkg.sv
package spi_msg_pkg;

    // ============================================================
    // Message layout
    // ============================================================

    // Message length in bits, sent as 4-bit nibbles
    localparam int MSG_LEN = 64;

    // Leading nibbles that the host sends ahead of every message
    localparam int DUMMY_NIBBLES = 2;

    // 8-bit type followed by a 56-bit argument
    typedef logic [7:0] msg_type_t;

    // Type values after the top bit is forced high; bit 6 marks a reply
    localparam msg_type_t MSG_TYPE_ECHO    = 8'hC0;
    localparam msg_type_t MSG_TYPE_READOUT = 8'hC1;
    localparam msg_type_t MSG_TYPE_LED_SET = 8'h80;
    localparam msg_type_t MSG_TYPE_NOP     = 8'h81;

    // LED set argument, value in the lowest bits
    typedef struct packed {
        logic [51:0] unused;
        logic [3:0]  val;
    } msg_led_t;

    // Same 56 argument bits seen two ways
    typedef union packed {
        logic [55:0] echo;
        msg_led_t    led;
    } msg_arg_u;

    // ============================================================
    // Receiver to sender
    // ============================================================

    typedef enum logic [1:0] {
        KIND_NONE    = 2'd0,
        KIND_ECHO    = 2'd1,
        KIND_READOUT = 2'd2
    } cmd_kind_t;

    typedef struct packed {
        logic        start;
        cmd_kind_t   kind;
        logic [55:0] payload;
    } spi_cmd_t;

    // FIFO word
    typedef logic [15:0] word_t;

endpackage

//--- hdl/nibble_packer.sv
module nibble_packer
    import spi_msg_pkg::*;
(
    input  logic       spi_clk,
    input  logic       spi_rst_,
    input  logic       dat_strobe,
    input  logic [3:0] dat,
    input  logic       full,
    output logic       push,
    output word_t      push_data
);

    // Position of the next nibble within the word
    logic [1:0]  nib_cnt;
    logic [11:0] nib_shift;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            nib_cnt <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            if (dat_strobe) begin
                nib_cnt <= nib_cnt + 2'd1;
                // Fourth nibble completes the word; dropped when the chain is full
                if (nib_cnt == 2'd3) begin
                    push <= !full;
                end
            end
        end
    end

    // Most significant nibble arrives first
    always_ff @(posedge spi_clk) begin
        if (dat_strobe) begin
            nib_shift <= {nib_shift[7:0], dat};
            if (nib_cnt == 2'd3) begin
                push_data <= {nib_shift, dat};
            end
        end
    end

endmodule

//--- hdl/fifo_stage.sv
module fifo_stage
    import spi_msg_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic  spi_clk,
    input  logic  spi_rst_,

    // Write side
    input  logic  w_trigger,
    input  word_t w_data,
    output logic  w_ready,

    // Read side, show-ahead
    input  logic  r_trigger,
    output word_t r_data,
    output logic  r_ready
);

    localparam int AW = $clog2(DEPTH);

    word_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] w_ptr;
    logic [AW:0] r_ptr;

    logic do_write;
    logic do_read;
    logic is_full;
    logic is_empty;

    assign is_empty = (w_ptr == r_ptr);
    assign is_full  = (w_ptr[AW] != r_ptr[AW]) && (w_ptr[AW-1:0] == r_ptr[AW-1:0]);

    assign w_ready = !is_full;
    assign r_ready = !is_empty;

    assign do_write = w_trigger && w_ready;
    assign do_read  = r_trigger && r_ready;

    // Oldest word is always on the output
    assign r_data = mem[r_ptr[AW-1:0]];

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            w_ptr <= '0;
            r_ptr <= '0;
        end else begin
            if (do_write) begin
                w_ptr <= w_ptr + 1'b1;
            end
            if (do_read) begin
                r_ptr <= r_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge spi_clk) begin
        if (do_write) begin
            mem[w_ptr[AW-1:0]] <= w_data;
        end
    end

endmodule

//--- hdl/fifo_chain.sv
module fifo_chain
    import spi_msg_pkg::*;
#(
    parameter int STAGE_COUNT = 4,
    parameter int STAGE_DEPTH = 8,
    parameter int CHUNK_WORDS = 16
) (
    input  logic  spi_clk,
    input  logic  spi_rst_,
    input  logic  push,
    input  word_t push_data,
    output logic  full,
    input  logic  pop,
    output word_t head,
    output logic  head_valid,
    output logic  data_ready
);

    localparam int CAPACITY = STAGE_COUNT * STAGE_DEPTH;
    localparam int LVL_W    = $clog2(CAPACITY + 1);

    logic [STAGE_COUNT-1:0] w_trig;
    logic [STAGE_COUNT-1:0] w_rdy;
    logic [STAGE_COUNT-1:0] r_trig;
    logic [STAGE_COUNT-1:0] r_rdy;
    word_t                  w_data [STAGE_COUNT];
    word_t                  r_data [STAGE_COUNT];

    // Total words held across all stages
    logic [LVL_W-1:0] level;

    // ============================================================
    // Stages
    // ============================================================
    for (genvar g = 0; g < STAGE_COUNT; g++) begin : g_stage
        if (g == 0) begin : g_head
            assign w_trig[0] = push;
            assign w_data[0] = push_data;
        end else begin : g_link
            // One word moves forward whenever there is one and room for it
            assign w_trig[g]   = r_rdy[g-1] && w_rdy[g];
            assign r_trig[g-1] = w_trig[g];
            assign w_data[g]   = r_data[g-1];
        end

        fifo_stage #(
            .DEPTH(STAGE_DEPTH)
        ) u_stage (
            .spi_clk  (spi_clk),
            .spi_rst_ (spi_rst_),
            .w_trigger(w_trig[g]),
            .w_data   (w_data[g]),
            .w_ready  (w_rdy[g]),
            .r_trigger(r_trig[g]),
            .r_data   (r_data[g]),
            .r_ready  (r_rdy[g])
        );
    end

    assign r_trig[STAGE_COUNT-1] = pop;
    assign head       = r_data[STAGE_COUNT-1];
    assign head_valid = r_rdy[STAGE_COUNT-1];
    assign full       = !w_rdy[0];

    // ============================================================
    // Level
    // ============================================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            level <= '0;
        end else begin
            case ({push && !full, pop && head_valid})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign data_ready = (level >= LVL_W'(CHUNK_WORDS));

endmodule

//--- hdl/spi_msg_rx.sv
module spi_msg_rx
    import spi_msg_pkg::*;
(
    input  logic       spi_clk,
    input  logic       spi_rst_,
    input  logic       cs_,
    input  logic [3:0] spi_d_in,
    output spi_cmd_t   cmd,
    output logic [3:0] led
);

    // Dummies plus message nibbles
    localparam int NIBBLES = DUMMY_NIBBLES + MSG_LEN / 4;
    localparam int CNT_W   = $clog2(NIBBLES + 2);

    logic [CNT_W-1:0]   nib_cnt;
    logic [MSG_LEN-1:0] msg_shift;

    msg_type_t msg_type_raw;
    msg_type_t msg_type;
    msg_arg_u  msg_arg;
    logic      decode;

    logic        start_q;
    cmd_kind_t   kind_q;
    logic [55:0] payload_q;

    // ============================================================
    // Message fields
    // ============================================================
    assign msg_type_raw = msg_shift[MSG_LEN-1 -: 8];
    // Host cannot send a leading 1, so the top bit is implied
    assign msg_type     = {1'b1, msg_type_raw[6:0]};
    assign msg_arg      = msg_shift[MSG_LEN-9:0];
    assign decode       = (nib_cnt == CNT_W'(NIBBLES));

    // Dummy nibbles fall off the top of the shift register
    always_ff @(posedge spi_clk) begin
        if (!cs_ && nib_cnt < CNT_W'(NIBBLES)) begin
            msg_shift <= {msg_shift[MSG_LEN-5:0], spi_d_in};
        end
    end

    // ============================================================
    // Framing and decode
    // ============================================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            nib_cnt <= '0;
            start_q <= 1'b0;
            kind_q  <= KIND_NONE;
            led     <= 4'd0;
        end else begin
            start_q <= 1'b0;
            if (cs_) begin
                nib_cnt <= '0;
            end else if (nib_cnt < CNT_W'(NIBBLES)) begin
                nib_cnt <= nib_cnt + 1'b1;
            end else if (decode) begin
                // Decode once, then wait for cs_ to rise
                nib_cnt <= nib_cnt + 1'b1;
                kind_q  <= KIND_NONE;
                case (msg_type)
                    MSG_TYPE_ECHO: begin
                        start_q <= 1'b1;
                        kind_q  <= KIND_ECHO;
                    end
                    MSG_TYPE_READOUT: begin
                        start_q <= 1'b1;
                        kind_q  <= KIND_READOUT;
                    end
                    MSG_TYPE_LED_SET: begin
                        led <= msg_arg.led.val;
                    end
                    MSG_TYPE_NOP: begin
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge spi_clk) begin
        if (decode) begin
            payload_q <= msg_arg.echo;
        end
    end

    assign cmd.start   = start_q;
    assign cmd.kind    = kind_q;
    assign cmd.payload = payload_q;

endmodule

//--- hdl/spi_tx.sv
module spi_tx
    import spi_msg_pkg::*;
#(
    parameter int CHUNK_WORDS = 16
) (
    input  logic       spi_clk,
    input  logic       spi_rst_,
    input  logic       cs_,
    input  spi_cmd_t   cmd,
    input  word_t      head,
    input  logic       head_valid,
    output logic       pop,
    output logic [7:0] spi_d_out,
    output logic       spi_d_oe
);

    localparam int WCNT_W = $clog2(CHUNK_WORDS + 1);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ECHO    = 2'd1,
        ST_READOUT = 2'd2
    } tx_state_t;

    tx_state_t state;

    // High byte of head goes out first, so the toggle starts on the low byte
    logic              byte_hi;
    logic [WCNT_W-1:0] word_cnt;
    logic [63:0]       dout_shift;

    logic start_echo;
    logic start_readout;
    logic chunk_done;

    assign start_echo    = cmd.start && (cmd.kind == KIND_ECHO);
    assign start_readout = cmd.start && (cmd.kind == KIND_READOUT);
    assign chunk_done    = (word_cnt == WCNT_W'(CHUNK_WORDS));

    // Word leaves the chain at the edge that latches its low byte
    assign pop = (state == ST_READOUT) && !byte_hi && head_valid;

    assign spi_d_out = dout_shift[63:56];

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state    <= ST_IDLE;
            spi_d_oe <= 1'b0;
            byte_hi  <= 1'b0;
            word_cnt <= '0;
        end else if (cs_) begin
            state    <= ST_IDLE;
            spi_d_oe <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    byte_hi  <= 1'b0;
                    word_cnt <= '0;
                    if (start_echo) begin
                        state    <= ST_ECHO;
                        spi_d_oe <= 1'b1;
                    end else if (start_readout) begin
                        state    <= ST_READOUT;
                        spi_d_oe <= 1'b1;
                    end
                end
                // Keeps shifting zeros until cs_ rises
                ST_ECHO: begin
                end
                ST_READOUT: begin
                    byte_hi <= !byte_hi;
                    if (!byte_hi) begin
                        word_cnt <= word_cnt + 1'b1;
                    end else if (chunk_done) begin
                        state    <= ST_IDLE;
                        spi_d_oe <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Output byte lanes
    // ============================================================
    always_ff @(posedge spi_clk) begin
        case (state)
            ST_IDLE: begin
                if (start_echo) begin
                    // Payload then one zero byte
                    dout_shift <= {cmd.payload, 8'h00};
                end else if (start_readout) begin
                    dout_shift[63:56] <= head[15:8];
                end
            end
            ST_ECHO: begin
                dout_shift <= {dout_shift[55:0], 8'h00};
            end
            ST_READOUT: begin
                dout_shift[63:56] <= byte_hi ? head[15:8] : head[7:0];
            end
            default: begin
                dout_shift <= dout_shift;
            end
        endcase
    end

endmodule

//--- hdl/spi_top.sv
module spi_top
    import spi_msg_pkg::*;
#(
    parameter int STAGE_COUNT = 4,
    parameter int STAGE_DEPTH = 8,
    parameter int CHUNK_WORDS = 16
) (
    input  logic       spi_clk,
    input  logic       spi_rst_,
    input  logic       cs_,
    input  logic [3:0] spi_d_in,
    output logic [7:0] spi_d_out,
    output logic       spi_d_oe,
    input  logic       dat_strobe,
    input  logic [3:0] dat,
    output logic       data_ready,
    output logic [3:0] led
);

    // Fill path
    logic  push;
    word_t push_data;
    logic  full;

    // Drain path
    logic  pop;
    word_t head;
    logic  head_valid;

    spi_cmd_t cmd;

    nibble_packer u_packer (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .dat_strobe(dat_strobe),
        .dat       (dat),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    fifo_chain #(
        .STAGE_COUNT(STAGE_COUNT),
        .STAGE_DEPTH(STAGE_DEPTH),
        .CHUNK_WORDS(CHUNK_WORDS)
    ) u_chain (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .head      (head),
        .head_valid(head_valid),
        .data_ready(data_ready)
    );

    spi_msg_rx u_rx (
        .spi_clk (spi_clk),
        .spi_rst_(spi_rst_),
        .cs_     (cs_),
        .spi_d_in(spi_d_in),
        .cmd     (cmd),
        .led     (led)
    );

    spi_tx #(
        .CHUNK_WORDS(CHUNK_WORDS)
    ) u_tx (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .cs_       (cs_),
        .cmd       (cmd),
        .head      (head),
        .head_valid(head_valid),
        .pop       (pop),
        .spi_d_out (spi_d_out),
        .spi_d_oe  (spi_d_oe)
    );

endmodule

//--- tests/spi_top_sva.sv
module fifo_chain_checks #(
    parameter int CAPACITY = 32,
    parameter int LVL_W    = 6
) (
    input logic             spi_clk,
    input logic             spi_rst_,
    input logic             push,
    input logic             full,
    input logic             pop,
    input logic             head_valid,
    input logic [LVL_W-1:0] level
);

    // Sender only takes a word that is there
    pop_has_head: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_) pop |-> head_valid
    ) else $error("pop while the chain head is empty");

    // Packer drops words instead of pushing into a full chain
    push_not_full: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_) push |-> !full
    ) else $error("push while the first stage is full");

    level_in_range: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_) level <= LVL_W'(CAPACITY)
    ) else $error("chain level above capacity");

endmodule

bind fifo_chain fifo_chain_checks #(
    .CAPACITY(CAPACITY),
    .LVL_W   (LVL_W)
) u_checks (
    .spi_clk   (spi_clk),
    .spi_rst_  (spi_rst_),
    .push      (push),
    .full      (full),
    .pop       (pop),
    .head_valid(head_valid),
    .level     (level)
);

//--- tests/tb_spi_top.sv
module tb_spi_top;

    localparam int CHUNK      = 16;
    localparam int WAIT_LIMIT = 40;

    logic       spi_clk;
    logic       spi_rst_;
    logic       cs_;
    logic [3:0] spi_d_in;
    logic [7:0] spi_d_out;
    logic       spi_d_oe;
    logic       dat_strobe;
    logic [3:0] dat;
    logic       data_ready;
    logic [3:0] led;

    // Words written but not yet read back, oldest first
    logic [15:0] model_q[$];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests;
    bit          timed_out;

    spi_top uut (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .cs_       (cs_),
        .spi_d_in  (spi_d_in),
        .spi_d_out (spi_d_out),
        .spi_d_oe  (spi_d_oe),
        .dat_strobe(dat_strobe),
        .dat       (dat),
        .data_ready(data_ready),
        .led       (led)
    );

    always #4 spi_clk = ~spi_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Inputs change 1 unit after the edge, outputs are read at the same point
    task automatic step();
        @(posedge spi_clk);
        #1;
    endtask

    // ============================================================
    // Host side
    // ============================================================

    // Returns after edge 18, the last nibble sampled
    task automatic send_message(input logic [7:0] mtype, input logic [55:0] arg);
        logic [63:0] msg;
        msg = {mtype, arg};
        cs_ = 1'b0;
        spi_d_in = 4'ha;
        for (int k = 1; k <= 18; k++) begin
            step();
            checks++;
            if (spi_d_oe !== 1'b0) begin
                $display("Error at %0t: spi_d_oe high while nibble %0d is sent", $time, k);
                errors++;
            end
            // Two dummy nibbles, then the message
            if (k < 2) begin
                spi_d_in = 4'ha;
            end else if (k < 18) begin
                spi_d_in = msg[63 - 4 * (k - 2) -: 4];
            end
        end
    endtask

    task automatic wait_oe(input logic want, output int cycles);
        cycles = 0;
        do begin
            step();
            cycles++;
        end while (spi_d_oe !== want && cycles < WAIT_LIMIT);
        if (spi_d_oe !== want) begin
            $display("Timeout: spi_d_oe did not become %b within %0d cycles (time %0t)",
                     want, WAIT_LIMIT, $time);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic end_message();
        cs_ = 1'b1;
        step();
        checks++;
        if (spi_d_oe !== 1'b0) begin
            $display("Error at %0t: spi_d_oe still high after cs_ rose", $time);
            errors++;
        end
        step();
    endtask

    task automatic run_echo(input logic [7:0] mtype, input logic [55:0] arg);
        int          cycles;
        logic [71:0] reply;
        // Payload, the zero byte, then one zero filler byte
        reply = {arg, 16'h0000};
        send_message(mtype, arg);
        wait_oe(1'b1, cycles);
        if (timed_out) begin
            return;
        end
        checks++;
        if (cycles != 2) begin
            $display("Error at %0t: reply began after edge %0d, expected 20", $time, 18 + cycles);
            errors++;
        end
        for (int i = 0; i < 9; i++) begin
            if (i > 0) begin
                step();
            end
            checks++;
            if (spi_d_oe !== 1'b1 || spi_d_out !== reply[71 - 8 * i -: 8]) begin
                $display("Error at %0t: echo byte %0d is %h (oe %b), expected %h",
                         $time, i, spi_d_out, spi_d_oe, reply[71 - 8 * i -: 8]);
                errors++;
            end
        end
        end_message();
    endtask

    task automatic run_quiet(input logic [7:0] mtype, input logic [55:0] arg);
        send_message(mtype, arg);
        // Edges 19 to 30
        for (int i = 0; i < 12; i++) begin
            step();
            checks++;
            if (spi_d_oe !== 1'b0) begin
                $display("Error at %0t: spi_d_oe high after edge %0d", $time, 19 + i);
                errors++;
            end
        end
        end_message();
    endtask

    task automatic run_readout();
        int          cycles;
        logic [15:0] word;
        logic [7:0]  exp;
        checks++;
        if (model_q.size() < CHUNK) begin
            $display("Error at %0t: readout with only %0d words written", $time, model_q.size());
            errors++;
            return;
        end
        send_message(8'h41, 56'd0);
        wait_oe(1'b1, cycles);
        if (timed_out) begin
            return;
        end
        checks++;
        if (cycles != 2) begin
            $display("Error at %0t: readout began after edge %0d, expected 20", $time, 18 + cycles);
            errors++;
        end
        for (int b = 0; b < 2 * CHUNK; b++) begin
            if (b > 0) begin
                step();
            end
            if (b[0] == 1'b0) begin
                word = model_q.pop_front();
            end
            exp = b[0] ? word[7:0] : word[15:8];
            checks++;
            if (spi_d_oe !== 1'b1 || spi_d_out !== exp) begin
                $display("Error at %0t: readout byte %0d is %h (oe %b), expected %h",
                         $time, b, spi_d_out, spi_d_oe, exp);
                errors++;
            end
        end
        wait_oe(1'b0, cycles);
        if (timed_out) begin
            return;
        end
        checks++;
        if (cycles != 1) begin
            $display("Error at %0t: spi_d_oe fell %0d cycles after the last byte", $time, cycles);
            errors++;
        end
        end_message();
        checks++;
        if (data_ready !== (model_q.size() >= CHUNK)) begin
            $display("Error at %0t: data_ready is %b with %0d words left",
                     $time, data_ready, model_q.size());
            errors++;
        end
    endtask

    // ============================================================
    // Fill side
    // ============================================================
    task automatic write_words(input int n);
        logic [15:0] word;
        for (int w = 0; w < n; w++) begin
            lcg_state = lcg_next(lcg_state);
            word = lcg_state[31:16];
            model_q.push_back(word);
            for (int k = 0; k < 4; k++) begin
                dat_strobe = 1'b1;
                dat = word[15 - 4 * k -: 4];
                step();
            end
            dat_strobe = 1'b0;
            // Level counts the word one edge after the push
            step();
            checks++;
            if (data_ready !== (model_q.size() >= CHUNK)) begin
                $display("Error at %0t: data_ready is %b with %0d words written",
                         $time, data_ready, model_q.size());
                errors++;
            end
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int          fd;
        int          n;
        int          errs_before;
        string       line;
        string       op_name;
        byte         op;
        logic [7:0]  mtype;
        logic [55:0] arg;
        logic [3:0]  exp_led;
        logic        echo;
        spi_clk    = 1'b0;
        spi_rst_   = 1'b0;
        cs_        = 1'b1;
        spi_d_in   = 4'd0;
        dat_strobe = 1'b0;
        dat        = 4'd0;
        lcg_state  = 32'd44739;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        timed_out  = 1'b0;
        repeat (2) @(posedge spi_clk);
        #1;
        spi_rst_ = 1'b1;
        step();
        checks++;
        if (spi_d_oe !== 1'b0 || led !== 4'd0 || data_ready !== 1'b0) begin
            $display("Error at %0t: after reset oe %b led %h data_ready %b, expected all 0",
                     $time, spi_d_oe, led, data_ready);
            errors++;
        end
        $display("Test 0 reset: %s", (errors == 0) ? "ok" : "mismatch");

        fd = $fopen("tests/spi_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/spi_cases.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                op = (line.len() > 0) ? line.getc(0) : 8'h00;
                if (op == "W" || op == "M" || op == "R") begin
                    errs_before = errors;
                    tests++;
                    case (op)
                        "W": begin
                            n = 0;
                            void'($sscanf(line.substr(2, line.len() - 1), "%d", n));
                            op_name = $sformatf("write %0d words", n);
                            write_words(n);
                        end
                        "M": begin
                            void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
                                          mtype, arg, exp_led, echo));
                            op_name = $sformatf("message type %h", mtype);
                            if (echo) begin
                                run_echo(mtype, arg);
                            end else begin
                                run_quiet(mtype, arg);
                            end
                            checks++;
                            if (!timed_out && led !== exp_led) begin
                                $display("Error at %0t: led is %h, expected %h", $time, led, exp_led);
                                errors++;
                            end
                        end
                        default: begin
                            op_name = "readout";
                            run_readout();
                        end
                    endcase
                    $display("Test %0d %s: %s", tests, op_name,
                             (errors == errs_before) ? "ok" : "mismatch");
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/spi_cases.txt
# One operation per line, numbers in hex except the W word count
#   W <count>                     write count LCG words through the nibble bus
#   M <type> <arg> <led> <echo>   send a message, expected led after it, echo 1 for a reply
#   R                             read one chunk of 16 words
M 40 0123456789abcd 0 1
M 00 fffffffffffff5 5 0
M 01 00000000000000 5 0
M 95 0000000000000c 5 0
W 8
M c0 a5a55a5a00ff11 5 1
W 8
R
W 10
M 00 00000000000003 3 0
W 8
R
W 20
R
M 95 00000000000007 3 0
W 10
R
M 01 0000000000000e 3 0

//--- compile.f
hdl/spi_msg_pkg.sv
hdl/nibble_packer.sv
hdl/fifo_stage.sv
hdl/fifo_chain.sv
hdl/spi_msg_rx.sv
hdl/spi_tx.sv
hdl/spi_top.sv
tests/spi_top_sva.sv
tests/tb_spi_top.sv

//--- Makefile
TOP := tb_spi_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
